/* hw/copper_macros.svh */
`ifndef COPPER_MACROS_SVH
`define COPPER_MACROS_SVH

// Datapath widths
`define COPPER_PC_W           11
`define COPPER_DATA_W         16
`define COPPER_POS_W          11
`define COPPER_XR_ADDR_W      16
`define COPPER_REG_NUM_W      4

// Instruction word split, opcode nibble then operand
`define COPPER_OPCODE_W       4
`define COPPER_OPERAND_W      12

// Fixed 640x480 frame totals
`define COPPER_H_TOTAL        800
`define COPPER_V_TOTAL        525

// Restart a few clocks before the frame wraps
`define COPPER_RESTART_H      (`COPPER_H_TOTAL - 5)
`define COPPER_RESTART_V      (`COPPER_V_TOTAL - 1)

// Control register number and enable bit
`define COPPER_CTRL_REG_NUM   4'h1
`define COPPER_CTRL_EN_BIT    15

// XR region bases for MOVEF, MOVEP and MOVEC
`define COPPER_TILE_BASE      16'h4000
`define COPPER_COLOR_BASE     16'h8000
`define COPPER_COPPER_BASE    16'hC000

// Address bits taken from the operand per MOVE variant
`define COPPER_REG_ADDR_W     8
`define COPPER_TILE_ADDR_W    12
`define COPPER_COLOR_ADDR_W   8
`define COPPER_COPMEM_ADDR_W  11

// Second word of WAIT/SKIP: X in [14:4], flags in [3:0]
`define COPPER_X_LSB          4
`define COPPER_FLAG_IGN_V     0
`define COPPER_FLAG_IGN_H     1

// PC step for a taken SKIP jumps over one two-word insn
`define COPPER_SKIP_STEP      3

`endif

/* hw/copper_pkg.sv */
`include "copper_macros.svh"

package copper_pkg;

    // Top nibble of the first instruction word
    typedef enum logic [`COPPER_OPCODE_W-1:0] {
        OP_WAIT  = 4'b0000,
        OP_SKIP  = 4'b0010,
        OP_JMP   = 4'b0100,
        // All MOVE variants carry data in the second word
        OP_MOVER = 4'b1001,
        OP_MOVEF = 4'b1010,
        OP_MOVEP = 4'b1011,
        OP_MOVEC = 4'b1100
    } opcode_e;

    // Sequencer execution states
    typedef enum logic [2:0] {
        // Only after enable or frame restart, primes the first fetch
        ST_INIT    = 3'd0,
        // Word 1 address on the bus
        ST_FETCH   = 3'd1,
        // Word 1 data returns, word 2 address on the bus
        ST_LATCH1  = 3'd2,
        // Word 2 data returns
        ST_LATCH2  = 3'd3,
        ST_EXEC    = 3'd4,
        // Position check for WAIT
        ST_EX_WAIT = 3'd5,
        // Position check for SKIP
        ST_EX_SKIP = 3'd6
    } state_e;

    // Both latched words, first word in the upper half
    typedef struct packed {
        opcode_e                      opcode;
        // Y position, jump target or MOVE address
        logic [`COPPER_OPERAND_W-1:0] operand;
        // X and flags, or MOVE data
        logic [`COPPER_DATA_W-1:0]    word2;
    } insn_t;

endpackage

/* hw/copper_exec_if.sv */
`timescale 1ns/1ps

interface copper_exec_if;

    // Latched instruction, owned by the sequencer
    copper_pkg::insn_t insn;

    // Sample beam position for WAIT/SKIP
    logic pos_sample;
    // Sampled position satisfies the condition
    logic pos_met;

    // MOVE handshake, completes when both are high
    logic move_req;
    logic move_ack;

    modport seq (
        output insn,
        output pos_sample,
        output move_req,
        input  pos_met,
        input  move_ack
    );

    modport beam (
        input  insn,
        input  pos_sample,
        output pos_met
    );

    modport move (
        input  insn,
        input  move_req,
        output move_ack
    );

endinterface

/* hw/copper_sequencer.sv */
`timescale 1ns/1ps
`include "copper_macros.svh"

module copper_sequencer (
    input  logic                         clk,
    input  logic                         copp_reset,
    input  logic                         ctrl_wr_i,
    input  logic [`COPPER_REG_NUM_W-1:0] ctrl_num_i,
    input  logic [`COPPER_DATA_W-1:0]    ctrl_data_i,
    input  logic [`COPPER_DATA_W-1:0]    coppermem_rd_data_i,
    input  logic                         frame_restart_i,
    output logic                         coppermem_rd_en_o,
    output logic [`COPPER_PC_W-1:0]      coppermem_rd_addr_o,
    copper_exec_if.seq                   exec_if
);

    // Control register fields
    logic                    copper_en;
    logic [`COPPER_PC_W-1:0] init_pc;

    logic [`COPPER_PC_W-1:0] pc;
    copper_pkg::state_e      state;
    copper_pkg::insn_t       insn;
    logic                    rd_strobe;

    // Sequencer may act this cycle
    logic                    active;
    logic                    is_pos;
    logic                    is_move;
    logic                    skip_taken;

    assign active = copper_en && !frame_restart_i;

    // Opcode class decode
    always_comb begin
        is_pos  = 1'b0;
        is_move = 1'b0;
        case (insn.opcode)
            copper_pkg::OP_WAIT,
            copper_pkg::OP_SKIP:  is_pos = 1'b1;
            copper_pkg::OP_MOVER,
            copper_pkg::OP_MOVEF,
            copper_pkg::OP_MOVEP,
            copper_pkg::OP_MOVEC: is_move = 1'b1;
            default: ;
        endcase
    end

    // SKIP with both position checks ignored always skips
    assign skip_taken = exec_if.pos_met ||
                        (insn.word2[`COPPER_FLAG_IGN_V] && insn.word2[`COPPER_FLAG_IGN_H]);

    assign exec_if.insn       = insn;
    assign exec_if.pos_sample = active && (state == copper_pkg::ST_EXEC) && is_pos;
    assign exec_if.move_req   = active && (state == copper_pkg::ST_EXEC) && is_move;

    // PC drives the program memory address directly
    assign coppermem_rd_en_o   = rd_strobe;
    assign coppermem_rd_addr_o = pc;

    // Control register, only number 1 decoded
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en <= 1'b0;
            init_pc   <= '0;
        end else if (ctrl_wr_i && ctrl_num_i == `COPPER_CTRL_REG_NUM) begin
            copper_en <= ctrl_data_i[`COPPER_CTRL_EN_BIT];
            init_pc   <= ctrl_data_i[`COPPER_PC_W-1:0];
        end
    end

    // Fetch/execute FSM
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state     <= copper_pkg::ST_INIT;
            pc        <= '0;
            rd_strobe <= 1'b0;
        end else if (frame_restart_i) begin
            // New frame, back to the start of the list
            state     <= copper_pkg::ST_INIT;
            pc        <= init_pc;
            rd_strobe <= 1'b0;
        end else if (copper_en) begin
            case (state)
                copper_pkg::ST_INIT: begin
                    state     <= copper_pkg::ST_FETCH;
                    rd_strobe <= 1'b1;
                end
                copper_pkg::ST_FETCH: begin
                    // Step to the second word
                    pc        <= pc + 1'b1;
                    rd_strobe <= 1'b1;
                    state     <= copper_pkg::ST_LATCH1;
                end
                copper_pkg::ST_LATCH1: begin
                    state <= copper_pkg::ST_LATCH2;
                end
                copper_pkg::ST_LATCH2: begin
                    rd_strobe <= 1'b0;
                    state     <= copper_pkg::ST_EXEC;
                end
                copper_pkg::ST_EXEC: begin
                    case (insn.opcode)
                        copper_pkg::OP_WAIT: state <= copper_pkg::ST_EX_WAIT;
                        copper_pkg::OP_SKIP: state <= copper_pkg::ST_EX_SKIP;
                        copper_pkg::OP_JMP: begin
                            pc        <= insn.operand[`COPPER_PC_W-1:0];
                            rd_strobe <= 1'b1;
                            state     <= copper_pkg::ST_FETCH;
                        end
                        copper_pkg::OP_MOVER,
                        copper_pkg::OP_MOVEF,
                        copper_pkg::OP_MOVEP,
                        copper_pkg::OP_MOVEC: begin
                            // Hold here while the target is busy
                            if (exec_if.move_ack) begin
                                pc        <= pc + 1'b1;
                                rd_strobe <= 1'b1;
                                state     <= copper_pkg::ST_FETCH;
                            end
                        end
                        default: begin
                            // Illegal opcode, plain four-cycle no-op
                            pc        <= pc + 1'b1;
                            rd_strobe <= 1'b1;
                            state     <= copper_pkg::ST_FETCH;
                        end
                    endcase
                end
                copper_pkg::ST_EX_WAIT: begin
                    if (exec_if.pos_met) begin
                        pc        <= pc + 1'b1;
                        rd_strobe <= 1'b1;
                        state     <= copper_pkg::ST_FETCH;
                    end else begin
                        // Resample the beam next cycle
                        state <= copper_pkg::ST_EXEC;
                    end
                end
                copper_pkg::ST_EX_SKIP: begin
                    pc        <= skip_taken ? pc + `COPPER_PC_W'(`COPPER_SKIP_STEP) : pc + 1'b1;
                    rd_strobe <= 1'b1;
                    state     <= copper_pkg::ST_FETCH;
                end
                default: state <= copper_pkg::ST_INIT;
            endcase
        end
    end

    // Instruction latch, words arrive one cycle after their address
    always_ff @(posedge clk) begin
        if (active && state == copper_pkg::ST_LATCH1) begin
            insn.opcode  <= copper_pkg::opcode_e'(
                coppermem_rd_data_i[`COPPER_DATA_W-1 -: `COPPER_OPCODE_W]);
            insn.operand <= coppermem_rd_data_i[`COPPER_OPERAND_W-1:0];
        end
        if (active && state == copper_pkg::ST_LATCH2) begin
            insn.word2 <= coppermem_rd_data_i;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (copp_reset)
        state inside {copper_pkg::ST_INIT, copper_pkg::ST_FETCH, copper_pkg::ST_LATCH1,
                      copper_pkg::ST_LATCH2, copper_pkg::ST_EXEC, copper_pkg::ST_EX_WAIT,
                      copper_pkg::ST_EX_SKIP});

    // Stalled MOVE must not lose its place
    a_pc_hold_on_stall: assert property (@(posedge clk) disable iff (copp_reset)
        (state == copper_pkg::ST_EXEC && exec_if.move_req && !exec_if.move_ack)
        |=> $stable(pc));

endmodule

/* hw/copper_beam_compare.sv */
`timescale 1ns/1ps
`include "copper_macros.svh"

module copper_beam_compare (
    input  logic                     clk,
    input  logic                     copp_reset,
    input  logic [`COPPER_POS_W-1:0] h_count_i,
    input  logic [`COPPER_POS_W-1:0] v_count_i,
    output logic                     frame_restart_o,
    copper_exec_if.beam              exec_if
);

    localparam logic [`COPPER_POS_W-1:0] RESTART_H = `COPPER_RESTART_H;
    localparam logic [`COPPER_POS_W-1:0] RESTART_V = `COPPER_RESTART_V;

    logic at_restart;
    logic v_reached;
    logic h_reached;
    logic ign_v;
    logic ign_h;

    // Beam sits on the restart position
    assign at_restart = (h_count_i == RESTART_H) && (v_count_i == RESTART_V);

    // Counters pass the restart position once per frame
    assign frame_restart_o = at_restart;

    // Compare results captured in EXEC, used in EX_WAIT/EX_SKIP
    always_ff @(posedge clk) begin
        if (exec_if.pos_sample) begin
            v_reached <= v_count_i >= exec_if.insn.operand[`COPPER_POS_W-1:0];
            h_reached <= h_count_i >= exec_if.insn.word2[`COPPER_X_LSB +: `COPPER_POS_W];
        end
    end

    assign ign_v = exec_if.insn.word2[`COPPER_FLAG_IGN_V];
    assign ign_h = exec_if.insn.word2[`COPPER_FLAG_IGN_H];

    // Ignored axes count as reached
    // Both ignored never satisfies, so WAIT parks until the frame ends
    assign exec_if.pos_met = (v_reached || ign_v) && (h_reached || ign_h) && !(ign_v && ign_h);

    a_restart_single: assert property (@(posedge clk) disable iff (copp_reset)
        frame_restart_o |=> !frame_restart_o);

endmodule

/* hw/copper_move_unit.sv */
`timescale 1ns/1ps
`include "copper_macros.svh"

module copper_move_unit (
    input  logic                         clk,
    input  logic                         copp_reset,
    input  logic                         xr_reg_sel_i,
    input  logic                         tilemem_sel_i,
    input  logic                         colormem_sel_i,
    input  logic                         coppermem_sel_i,
    output logic                         xr_wr_en_o,
    output logic [`COPPER_XR_ADDR_W-1:0] xr_wr_addr_o,
    output logic [`COPPER_DATA_W-1:0]    xr_wr_data_o,
    copper_exec_if.move                  exec_if
);

    localparam int AW = `COPPER_XR_ADDR_W;

    localparam logic [AW-1:0] TILE_BASE   = `COPPER_TILE_BASE;
    localparam logic [AW-1:0] COLOR_BASE  = `COPPER_COLOR_BASE;
    localparam logic [AW-1:0] COPPER_BASE = `COPPER_COPPER_BASE;

    // Busy flag of the addressed target
    logic          target_sel;
    logic [AW-1:0] addr_next;

    // Region select and address forming per MOVE variant
    always_comb begin
        target_sel = 1'b1;
        addr_next  = '0;
        case (exec_if.insn.opcode)
            copper_pkg::OP_MOVER: begin
                // XR registers, high byte zero
                target_sel = xr_reg_sel_i;
                addr_next  = {{(AW-`COPPER_REG_ADDR_W){1'b0}},
                              exec_if.insn.operand[`COPPER_REG_ADDR_W-1:0]};
            end
            copper_pkg::OP_MOVEF: begin
                target_sel = tilemem_sel_i;
                addr_next  = {TILE_BASE[AW-1:`COPPER_TILE_ADDR_W],
                              exec_if.insn.operand[`COPPER_TILE_ADDR_W-1:0]};
            end
            copper_pkg::OP_MOVEP: begin
                target_sel = colormem_sel_i;
                addr_next  = {COLOR_BASE[AW-1:`COPPER_COLOR_ADDR_W],
                              exec_if.insn.operand[`COPPER_COLOR_ADDR_W-1:0]};
            end
            copper_pkg::OP_MOVEC: begin
                target_sel = coppermem_sel_i;
                addr_next  = {COPPER_BASE[AW-1:`COPPER_COPMEM_ADDR_W],
                              exec_if.insn.operand[`COPPER_COPMEM_ADDR_W-1:0]};
            end
            default: ;
        endcase
    end

    // Accept only while the host leaves the target alone
    assign exec_if.move_ack = exec_if.move_req && !target_sel;

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            xr_wr_en_o <= 1'b0;
        end else begin
            xr_wr_en_o <= exec_if.move_ack;
        end
    end

    // Write address and data, valid with the strobe
    always_ff @(posedge clk) begin
        if (exec_if.move_ack) begin
            xr_wr_addr_o <= addr_next;
            xr_wr_data_o <= exec_if.insn.word2;
        end
    end

    // Sequencer leaves EXEC after an accepted MOVE
    a_wr_single: assert property (@(posedge clk) disable iff (copp_reset)
        xr_wr_en_o |=> !xr_wr_en_o);

endmodule

/* hw/copper_top.sv */
`timescale 1ns/1ps
`include "copper_macros.svh"

module copper_top (
    input  logic                         clk,
    input  logic                         copp_reset,
    // Control register write port
    input  logic                         ctrl_wr_i,
    input  logic [`COPPER_REG_NUM_W-1:0] ctrl_num_i,
    input  logic [`COPPER_DATA_W-1:0]    ctrl_data_i,
    // Beam position
    input  logic [`COPPER_POS_W-1:0]     h_count_i,
    input  logic [`COPPER_POS_W-1:0]     v_count_i,
    // Program memory, registered read
    output logic                         coppermem_rd_en_o,
    output logic [`COPPER_PC_W-1:0]      coppermem_rd_addr_o,
    input  logic [`COPPER_DATA_W-1:0]    coppermem_rd_data_i,
    // Host busy flags per MOVE target
    input  logic                         xr_reg_sel_i,
    input  logic                         tilemem_sel_i,
    input  logic                         colormem_sel_i,
    input  logic                         coppermem_sel_i,
    // XR write port
    output logic                         xr_wr_en_o,
    output logic [`COPPER_XR_ADDR_W-1:0] xr_wr_addr_o,
    output logic [`COPPER_DATA_W-1:0]    xr_wr_data_o
);

    logic frame_restart;

    copper_exec_if exec_if ();

    copper_sequencer u_sequencer (
        .clk                 (clk),
        .copp_reset          (copp_reset),
        .ctrl_wr_i           (ctrl_wr_i),
        .ctrl_num_i          (ctrl_num_i),
        .ctrl_data_i         (ctrl_data_i),
        .coppermem_rd_data_i (coppermem_rd_data_i),
        .frame_restart_i     (frame_restart),
        .coppermem_rd_en_o   (coppermem_rd_en_o),
        .coppermem_rd_addr_o (coppermem_rd_addr_o),
        .exec_if             (exec_if.seq)
    );

    copper_beam_compare u_beam_compare (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .frame_restart_o (frame_restart),
        .exec_if         (exec_if.beam)
    );

    copper_move_unit u_move_unit (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .xr_reg_sel_i    (xr_reg_sel_i),
        .tilemem_sel_i   (tilemem_sel_i),
        .colormem_sel_i  (colormem_sel_i),
        .coppermem_sel_i (coppermem_sel_i),
        .xr_wr_en_o      (xr_wr_en_o),
        .xr_wr_addr_o    (xr_wr_addr_o),
        .xr_wr_data_o    (xr_wr_data_o),
        .exec_if         (exec_if.move)
    );

endmodule

/* verif/copper_tb_tasks.svh */
`ifndef COPPER_TB_TASKS_SVH
`define COPPER_TB_TASKS_SVH

task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
endtask

task automatic compare_addr(input string name, input logic [`COPPER_XR_ADDR_W-1:0] exp,
                            input logic [`COPPER_XR_ADDR_W-1:0] act);
    if (act !== exp) begin
        report_failure($sformatf("FAIL %s address expected %h actual %h", name, exp, act));
    end
endtask

task automatic compare_data(input string name, input logic [`COPPER_DATA_W-1:0] exp,
                            input logic [`COPPER_DATA_W-1:0] act);
    if (act !== exp) begin
        report_failure($sformatf("FAIL %s data expected %h actual %h", name, exp, act));
    end
endtask

task automatic compare_opcode(input string name, input copper_pkg::opcode_e exp,
                              input copper_pkg::opcode_e act);
    if (act !== exp) begin
        report_failure($sformatf("FAIL %s opcode expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_write(input string name, input int idx,
                           input logic [15:0] addr, input logic [15:0] data);
    compare_addr(name, addr, wr_addr_q[idx]);
    compare_data(name, data, wr_data_q[idx]);
endtask

function automatic copper_pkg::insn_t move_insn(input copper_pkg::opcode_e op,
                                                input logic [11:0] operand,
                                                input logic [15:0] data);
    copper_pkg::insn_t insn;
    insn.opcode  = op;
    insn.operand = operand;
    insn.word2   = data;
    return insn;
endfunction

// WAIT or SKIP, X in [14:4], ignore-H in bit 1, ignore-V in bit 0
function automatic copper_pkg::insn_t pos_insn(input copper_pkg::opcode_e op,
                                               input logic [10:0] y, input logic [10:0] x,
                                               input logic ign_v, input logic ign_h);
    return move_insn(op, {1'b0, y}, {1'b0, x, 2'b00, ign_h, ign_v});
endfunction

// Never satisfied, parks the copper until the frame restarts
function automatic copper_pkg::insn_t park_insn();
    return pos_insn(copper_pkg::OP_WAIT, 11'd0, 11'd0, 1'b1, 1'b1);
endfunction

// XR address of a MOVE from the region rule
function automatic logic [15:0] xr_addr_for(input copper_pkg::opcode_e op,
                                             input logic [11:0] operand);
    case (op)
        copper_pkg::OP_MOVEF: return {4'h4, operand};
        copper_pkg::OP_MOVEP: return {8'h80, operand[7:0]};
        copper_pkg::OP_MOVEC: return {5'b11000, operand[10:0]};
        default:              return {8'h00, operand[7:0]};
    endcase
endfunction

task automatic test_reset_enable();
    logic [10:0] addr;
    repeat (8) begin
        @(negedge clk);
        if (coppermem_rd_en_o || xr_wr_en_o) begin
            report_failure("reset_enable: bus activity right after reset");
        end
    end
    put_insn(12'h040, park_insn());
    // Register 2 is not decoded
    ctrl_write(4'h2, 16'h8040);
    repeat (10) begin
        @(negedge clk);
        if (coppermem_rd_en_o) begin
            report_failure("reset_enable: write to register 2 started the copper");
        end
    end
    start_program(11'h040);
    wait_read(addr, "reset_enable");
    compare_addr("reset_enable", 16'h0040, 16'(addr));
    // First word is latched at the end of ST_LATCH1
    repeat (2) @(negedge clk);
    compare_opcode("reset_enable", copper_pkg::OP_WAIT, uut.u_sequencer.insn.opcode);
endtask

task automatic test_moves();
    copper_pkg::opcode_e ops [4];
    logic [11:0]         opnd [4];
    logic [15:0]         data [4];
    ops  = '{copper_pkg::OP_MOVER, copper_pkg::OP_MOVEF,
             copper_pkg::OP_MOVEP, copper_pkg::OP_MOVEC};
    opnd = '{12'h0A5, 12'h123, 12'h0FE, 12'h5AB};
    for (int i = 0; i < 4; i++) begin
        data[i] = 16'($random(seed));
        put_insn(12'h040 + 2 * i, move_insn(ops[i], opnd[i], data[i]));
    end
    // Opcode 6 is undefined and must not write
    put_insn(12'h048, move_insn(copper_pkg::opcode_e'(4'h6), 12'hFFF, 16'hDEAD));
    put_insn(12'h04A, park_insn());
    start_program(11'h040);
    wait_writes(4, "moves");
    expect_quiet(40, 4, "moves");
    for (int i = 0; i < 4; i++) begin
        check_write("moves", i, xr_addr_for(ops[i], opnd[i]), data[i]);
    end
endtask

task automatic test_backpressure();
    logic [15:0] data;
    data = 16'($random(seed));
    put_insn(12'h040, move_insn(copper_pkg::OP_MOVEP, 12'h033, data));
    put_insn(12'h042, park_insn());
    wait_cycles(1);
    colormem_sel_i = 1'b1;
    start_program(11'h040);
    expect_quiet(20, 0, "backpressure");
    wait_cycles(1);
    colormem_sel_i = 1'b0;
    wait_writes(1, "backpressure");
    expect_quiet(20, 1, "backpressure");
    check_write("backpressure", 0, xr_addr_for(copper_pkg::OP_MOVEP, 12'h033), data);
endtask

task automatic test_wait();
    logic [15:0] data;
    data = 16'($random(seed));
    put_insn(12'h040, pos_insn(copper_pkg::OP_WAIT, 11'd100, 11'd200, 1'b0, 1'b0));
    put_insn(12'h042, move_insn(copper_pkg::OP_MOVER, 12'h011, data));
    put_insn(12'h044, park_insn());
    start_program(11'h040);
    expect_quiet(30, 0, "wait");
    // Line reached, column not yet
    set_beam(11'd100, 11'd150);
    expect_quiet(30, 0, "wait");
    set_beam(11'd100, 11'd200);
    wait_writes(1, "wait");
    check_write("wait", 0, 16'h0011, data);

    // Same target with the vertical check ignored
    data = 16'($random(seed));
    put_insn(12'h040, pos_insn(copper_pkg::OP_WAIT, 11'd100, 11'd200, 1'b1, 1'b0));
    put_insn(12'h042, move_insn(copper_pkg::OP_MOVER, 12'h011, data));
    start_program(11'h040);
    expect_quiet(30, 0, "wait_ign_v");
    set_beam(11'd0, 11'd200);
    wait_writes(1, "wait_ign_v");
    check_write("wait_ign_v", 0, 16'h0011, data);
endtask

task automatic test_skip_jmp();
    logic [15:0] d_a;
    logic [15:0] d_b;
    d_a = 16'($random(seed));
    d_b = 16'($random(seed));
    // Beam at origin, so Y=0 X=0 is met
    put_insn(12'h040, pos_insn(copper_pkg::OP_SKIP, 11'd0, 11'd0, 1'b0, 1'b0));
    put_insn(12'h042, move_insn(copper_pkg::OP_MOVER, 12'h021, d_a));
    put_insn(12'h044, move_insn(copper_pkg::OP_MOVER, 12'h022, d_b));
    put_insn(12'h046, park_insn());
    start_program(11'h040);
    wait_writes(1, "skip_met");
    expect_quiet(30, 1, "skip_met");
    check_write("skip_met", 0, 16'h0022, d_b);

    put_insn(12'h040, pos_insn(copper_pkg::OP_SKIP, 11'd500, 11'd700, 1'b0, 1'b0));
    start_program(11'h040);
    wait_writes(2, "skip_unmet");
    expect_quiet(30, 2, "skip_unmet");
    check_write("skip_unmet", 0, 16'h0021, d_a);
    check_write("skip_unmet", 1, 16'h0022, d_b);

    d_b = 16'($random(seed));
    put_insn(12'h040, move_insn(copper_pkg::OP_JMP, 12'h300, 16'h0000));
    put_insn(12'h042, move_insn(copper_pkg::OP_MOVER, 12'h031, d_a));
    put_insn(12'h044, park_insn());
    put_insn(12'h300, move_insn(copper_pkg::OP_MOVER, 12'h032, d_b));
    put_insn(12'h302, park_insn());
    start_program(11'h040);
    wait_writes(1, "jmp");
    expect_quiet(30, 1, "jmp");
    check_write("jmp", 0, 16'h0032, d_b);
endtask

task automatic test_frame_restart();
    logic [10:0] addr;
    put_insn(12'h100, park_insn());
    start_program(11'h100);
    wait_read(addr, "frame_restart");
    // Parked, so fetching stops
    expect_quiet(30, 0, "frame_restart");
    if (coppermem_rd_en_o) begin
        report_failure("frame_restart: copper kept fetching while parked");
    end
    pulse_restart();
    wait_read(addr, "frame_restart");
    compare_addr("frame_restart", 16'h0100, 16'(addr));
endtask

`endif

/* verif/copper_tb.sv */
`timescale 1ns/1ps
`include "copper_macros.svh"

module copper_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int MEM_WORDS       = 2048;
    // Longest wait for any single DUT response
    localparam int RESP_LIMIT      = 100;

    logic                         clk;
    logic                         copp_reset;
    logic                         ctrl_wr_i;
    logic [`COPPER_REG_NUM_W-1:0] ctrl_num_i;
    logic [`COPPER_DATA_W-1:0]    ctrl_data_i;
    logic [`COPPER_POS_W-1:0]     h_count_i;
    logic [`COPPER_POS_W-1:0]     v_count_i;
    logic                         coppermem_rd_en_o;
    logic [`COPPER_PC_W-1:0]      coppermem_rd_addr_o;
    logic [`COPPER_DATA_W-1:0]    coppermem_rd_data_i;
    logic                         xr_reg_sel_i;
    logic                         tilemem_sel_i;
    logic                         colormem_sel_i;
    logic                         coppermem_sel_i;
    logic                         xr_wr_en_o;
    logic [`COPPER_XR_ADDR_W-1:0] xr_wr_addr_o;
    logic [`COPPER_DATA_W-1:0]    xr_wr_data_o;

    integer seed;

    // Copper program memory model
    logic [`COPPER_DATA_W-1:0] prog_mem [MEM_WORDS];

    // Observed XR writes in order
    logic [`COPPER_XR_ADDR_W-1:0] wr_addr_q [$];
    logic [`COPPER_DATA_W-1:0]    wr_data_q [$];

    copper_top uut (
        .clk                 (clk),
        .copp_reset          (copp_reset),
        .ctrl_wr_i           (ctrl_wr_i),
        .ctrl_num_i          (ctrl_num_i),
        .ctrl_data_i         (ctrl_data_i),
        .h_count_i           (h_count_i),
        .v_count_i           (v_count_i),
        .coppermem_rd_en_o   (coppermem_rd_en_o),
        .coppermem_rd_addr_o (coppermem_rd_addr_o),
        .coppermem_rd_data_i (coppermem_rd_data_i),
        .xr_reg_sel_i        (xr_reg_sel_i),
        .tilemem_sel_i       (tilemem_sel_i),
        .colormem_sel_i      (colormem_sel_i),
        .coppermem_sel_i     (coppermem_sel_i),
        .xr_wr_en_o          (xr_wr_en_o),
        .xr_wr_addr_o        (xr_wr_addr_o),
        .xr_wr_data_o        (xr_wr_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Registered read, data one cycle after the address
    always @(posedge clk) begin
        if (coppermem_rd_en_o) begin
            coppermem_rd_data_i <= prog_mem[coppermem_rd_addr_o];
        end
    end

    // Sees the values from before the edge
    always @(posedge clk) begin
        if (!copp_reset && xr_wr_en_o) begin
            wr_addr_q.push_back(xr_wr_addr_o);
            wr_data_q.push_back(xr_wr_data_o);
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        report_failure("watchdog expired before the tests finished");
    end

    `include "copper_tb_tasks.svh"

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic ctrl_write(input logic [3:0] num, input logic [15:0] data);
        @(posedge clk);
        #1;
        ctrl_wr_i   = 1'b1;
        ctrl_num_i  = num;
        ctrl_data_i = data;
        @(posedge clk);
        #1;
        ctrl_wr_i = 1'b0;
    endtask

    task automatic set_beam(input logic [10:0] v, input logic [10:0] h);
        @(posedge clk);
        #1;
        v_count_i = v;
        h_count_i = h;
    endtask

    // One cycle on the restart position, then back to the frame origin
    task automatic pulse_restart();
        set_beam(11'(`COPPER_V_TOTAL - 1), 11'(`COPPER_H_TOTAL - 5));
        set_beam(11'd0, 11'd0);
    endtask

    // Stop, restart at the new PC while disabled, then enable
    task automatic start_program(input logic [10:0] pc);
        ctrl_write(4'h1, {5'b0, pc});
        pulse_restart();
        wr_addr_q.delete();
        wr_data_q.delete();
        ctrl_write(4'h1, {1'b1, 4'b0, pc});
    endtask

    task automatic put_insn(input int addr, input copper_pkg::insn_t insn);
        prog_mem[addr]     = insn[31:16];
        prog_mem[addr + 1] = insn[15:0];
    endtask

    task automatic wait_writes(input int n, input string name);
        int cycles;
        cycles = 0;
        while (wr_addr_q.size() < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESP_LIMIT) begin
                report_failure($sformatf("%s: expected XR write never appeared", name));
            end
        end
    endtask

    task automatic wait_read(output logic [10:0] addr, input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!coppermem_rd_en_o) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESP_LIMIT) begin
                report_failure($sformatf("%s: program memory was never read", name));
            end
        end
        addr = coppermem_rd_addr_o;
    endtask

    // No write beyond the expected count over n cycles
    task automatic expect_quiet(input int n, input int count, input string name);
        repeat (n) @(negedge clk);
        if (wr_addr_q.size() != count) begin
            report_failure($sformatf("FAIL %s write count expected %0d actual %0d",
                                     name, count, wr_addr_q.size()));
        end
    endtask

    initial begin
        seed            = 32'h19e46964;
        copp_reset      = 1'b1;
        ctrl_wr_i       = 1'b0;
        ctrl_num_i      = '0;
        ctrl_data_i     = '0;
        h_count_i       = '0;
        v_count_i       = '0;
        xr_reg_sel_i    = 1'b0;
        tilemem_sel_i   = 1'b0;
        colormem_sel_i  = 1'b0;
        coppermem_sel_i = 1'b0;
        coppermem_rd_data_i = '0;
        // Illegal opcode 7 with the address below, harmless no-ops
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog_mem[i] = {4'h7, 12'(i)};
        end
        wait_cycles(RESET_CYCLES);
        copp_reset = 1'b0;

        test_reset_enable();
        test_moves();
        test_backpressure();
        test_wait();
        test_skip_jmp();
        test_frame_restart();

        $display("** PASS **");
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
+incdir+verif
hw/copper_pkg.sv
hw/copper_exec_if.sv
hw/copper_sequencer.sv
hw/copper_beam_compare.sv
hw/copper_move_unit.sv
hw/copper_top.sv
verif/copper_tb.sv

/* Makefile */
# Verilator simulation of the copper testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = copper_tb
FILELIST = build.f
LOG      = sim.log

.PHONY: sim clean

# The run log decides the result, the simulator may stop on $fatal
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx '\*\* PASS \*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
